/* ctrl_settings.svh */
`ifndef CTRL_SETTINGS_SVH
`define CTRL_SETTINGS_SVH

// Datapath widths
`define CTRL_DATA_W    32           // Opcode window and immediate width
`define CTRL_REG_W     8            // Expanded register code
`define CTRL_WIN_BYTES 4            // Bytes per opcode window
`define CTRL_LEN_W     3            // Byte count width
`define CTRL_FLAGS_W   8            // Flag byte from the ALU

// First byte of each opcode group
`define CTRL_OP_NOP    8'h00
`define CTRL_OP_FLAG   8'h10        // RCF SCF CCF ZCF
`define CTRL_OP_JP16   8'h1a
`define CTRL_OP_JP24   8'h1b
`define CTRL_OP_LDB    8'h20        // LD R,# byte
`define CTRL_OP_LDW    8'h30        // LD R,# word
`define CTRL_OP_LDL    8'h40        // LD R,# long
`define CTRL_OP_JR     8'h60        // JR cc,d8 then JRL cc,d16 at +16

// Testbench
`define CTRL_TB_SEED   32'h7bf3

`endif

/* ctrl_pkg.sv */
`include "ctrl_settings.svh"

package ctrl_pkg;

    // Operations handed to the register file and ALU
    typedef enum logic [5:0] {
        ALU_NOP,
        ALU_MOVE,
        ALU_RCF,
        ALU_SCF,
        ALU_CCF,
        ALU_ZCF
    } alu_op_e;

    typedef enum logic [1:0] {
        JUMP_NONE,
        JUMP_REL,                               // PC plus target
        JUMP_ABS                                // PC loaded with target
    } jump_e;

    typedef enum logic [1:0] {
        SIZE_BYTE,
        SIZE_WORD,
        SIZE_LONG
    } size_e;

    // Flag byte layout
    localparam int FLAG_S = 7;
    localparam int FLAG_Z = 6;
    localparam int FLAG_V = 2;
    localparam int FLAG_C = 0;

    typedef struct packed {
        alu_op_e                 alu_op;
        logic [`CTRL_REG_W-1:0]  dst;
        logic [2:0]              regs_we;       // One-hot by operand size
        logic                    smux;          // Immediate as source
        logic                    flag_we;
        logic [`CTRL_DATA_W-1:0] imm;
    } alu_cmd_t;

    typedef struct packed {
        jump_e                   jump;
        logic [`CTRL_LEN_W-1:0]  len;           // Whole instruction in bytes
        logic [`CTRL_DATA_W-1:0] target;
        logic                    illegal;
    } pc_cmd_t;

endpackage

/* cond_eval.sv */
`include "ctrl_settings.svh"

module cond_eval (
    input  logic [3:0]               cc,
    input  logic [`CTRL_FLAGS_W-1:0] flags,
    output logic                     taken
);
    import ctrl_pkg::*;

    logic s_xor_v;
    logic base;

    assign s_xor_v = flags[FLAG_S] ^ flags[FLAG_V];

    // Codes 8 to 15 are the complements of 0 to 7
    always_comb begin
        case (cc[2:0])
            3'd0: base = 1'b0;                              // Never
            3'd1: base = s_xor_v;                           // Signed less
            3'd2: base = flags[FLAG_Z] | s_xor_v;           // Signed less or equal
            3'd3: base = flags[FLAG_Z] | flags[FLAG_C];     // Unsigned less or equal
            3'd4: base = flags[FLAG_V];                     // Overflow
            3'd5: base = flags[FLAG_S];                     // Minus
            3'd6: base = flags[FLAG_Z];                     // Equal
            default: base = flags[FLAG_C];                  // Carry
        endcase
    end

    assign taken = base ^ cc[3];

endmodule

/* op_decode.sv */
`include "ctrl_settings.svh"

module op_decode (
    input  logic [`CTRL_DATA_W-1:0]  op,
    input  logic [`CTRL_FLAGS_W-1:0] flags,
    output ctrl_pkg::alu_cmd_t       alu,
    output logic                     alu_en,
    output ctrl_pkg::pc_cmd_t        pc,
    output logic [`CTRL_LEN_W-1:0]   fetched,
    output logic                     need_fill,
    output ctrl_pkg::size_e          fill_size
);
    import ctrl_pkg::*;

    logic [7:0]              op0;
    logic                    taken;
    size_e                   ld_size;
    logic [`CTRL_DATA_W-1:0] rel_target;

    function automatic logic [2:0] expand_zz(input size_e sz);
        return (sz == SIZE_BYTE) ? 3'b001 : (sz == SIZE_WORD) ? 3'b010 : 3'b100;
    endfunction

    // Three-bit register field to full register code
    function automatic logic [`CTRL_REG_W-1:0] expand_reg(input logic [2:0] r, input size_e sz);
        logic [`CTRL_REG_W-1:0] code;
        if (sz == SIZE_BYTE) begin
            code = {4'he, r[2:1], 1'b0, ~r[0]};
        end else if (r[2]) begin
            code = {4'hf, r[1:0], 2'd0};
        end else begin
            code = {4'he, r[1:0], 2'd0};
        end
        return code;
    endfunction

    assign op0 = op[7:0];

    cond_eval u_cond (
        .cc    (op0[3:0]),
        .flags (flags),
        .taken (taken)
    );

    always_comb begin
        ld_size = (op0[6:4] == 3'd2) ? SIZE_BYTE : (op0[6:4] == 3'd3) ? SIZE_WORD : SIZE_LONG;
        if (op0[4]) begin                                   // JRL, 16-bit offset
            rel_target = {{(`CTRL_DATA_W-16){op[23]}}, op[23:8]} + `CTRL_DATA_W'(3);
        end else begin
            rel_target = {{(`CTRL_DATA_W-8){op[15]}}, op[15:8]} + `CTRL_DATA_W'(2);
        end
    end

    always_comb begin
        alu        = '0;
        alu.alu_op = ALU_NOP;
        alu_en     = 1'b0;
        pc         = '0;
        pc.jump    = JUMP_NONE;
        pc.len     = `CTRL_LEN_W'(1);
        fetched    = `CTRL_LEN_W'(1);
        need_fill  = 1'b0;
        fill_size  = SIZE_BYTE;
        case (op0) inside
            `CTRL_OP_NOP: ;
            [`CTRL_OP_FLAG : `CTRL_OP_FLAG + 8'd3]: begin
                alu_en      = 1'b1;
                alu.flag_we = 1'b1;
                case (op0[1:0])
                    2'd0: alu.alu_op = ALU_RCF;
                    2'd1: alu.alu_op = ALU_SCF;
                    2'd2: alu.alu_op = ALU_CCF;
                    default: alu.alu_op = ALU_ZCF;
                endcase
            end
            [`CTRL_OP_LDB : `CTRL_OP_LDB + 8'd7],
            [`CTRL_OP_LDW : `CTRL_OP_LDW + 8'd7],
            [`CTRL_OP_LDL : `CTRL_OP_LDL + 8'd7]: begin
                alu_en      = 1'b1;
                alu.alu_op  = ALU_MOVE;
                alu.dst     = expand_reg(op0[2:0], ld_size);
                alu.regs_we = expand_zz(ld_size);
                alu.smux    = 1'b1;
                alu.imm     = `CTRL_DATA_W'(op[15:8]);    // Low byte, rest from fill
                fetched     = `CTRL_LEN_W'(2);
                need_fill   = (ld_size != SIZE_BYTE);
                fill_size   = ld_size;
                case (ld_size)
                    SIZE_BYTE: pc.len = `CTRL_LEN_W'(2);
                    SIZE_WORD: pc.len = `CTRL_LEN_W'(3);
                    default:   pc.len = `CTRL_LEN_W'(5);
                endcase
            end
            `CTRL_OP_JP16, `CTRL_OP_JP24: begin
                pc.jump   = JUMP_ABS;
                pc.target = `CTRL_DATA_W'(op[15:8]);
                pc.len    = op0[0] ? `CTRL_LEN_W'(4) : `CTRL_LEN_W'(3);
                fetched   = `CTRL_LEN_W'(2);
                need_fill = 1'b1;
                fill_size = op0[0] ? SIZE_LONG : SIZE_WORD; // Long here means 24 bits
            end
            [`CTRL_OP_JR : `CTRL_OP_JR + 8'h1f]: begin
                pc.len  = op0[4] ? `CTRL_LEN_W'(3) : `CTRL_LEN_W'(2);
                fetched = pc.len;
                if (taken) begin
                    pc.jump   = JUMP_REL;
                    pc.target = rel_target;
                end
            end
            default: pc.illegal = 1'b1;                    // Skip one byte
        endcase
    end

endmodule

/* imm_fill.sv */
`include "ctrl_settings.svh"

module imm_fill (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    load,
    input  ctrl_pkg::alu_cmd_t      alu_in,
    input  ctrl_pkg::pc_cmd_t       pc_in,
    input  ctrl_pkg::size_e         size,
    input  logic [`CTRL_DATA_W-1:0] op,
    output ctrl_pkg::alu_cmd_t      alu_out,
    output ctrl_pkg::pc_cmd_t       pc_out,
    output logic [`CTRL_LEN_W-1:0]  fill_len
);
    import ctrl_pkg::*;

    alu_cmd_t alu_q;
    pc_cmd_t  pc_q;
    size_e    size_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            size_q <= SIZE_BYTE;
        end else if (load) begin
            size_q <= size;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            alu_q <= alu_in;
            pc_q  <= pc_in;
        end
    end

    // Upper bytes come from the start of the second window
    always_comb begin
        alu_out  = alu_q;
        pc_out   = pc_q;
        fill_len = '0;
        if (pc_q.jump == JUMP_ABS) begin
            if (size_q == SIZE_LONG) begin
                pc_out.target[23:8] = op[15:0];             // JP #24
                fill_len            = `CTRL_LEN_W'(2);
            end else begin
                pc_out.target[15:8] = op[7:0];
                fill_len            = `CTRL_LEN_W'(1);
            end
        end else begin
            case (size_q)
                SIZE_WORD: begin
                    alu_out.imm[15:8] = op[7:0];
                    fill_len          = `CTRL_LEN_W'(1);
                end
                SIZE_LONG: begin
                    alu_out.imm[31:8] = op[23:0];
                    fill_len          = `CTRL_LEN_W'(3);
                end
                default: ;
            endcase
        end
    end

endmodule

/* cmd_slot.sv */
module cmd_slot #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  payload_t in_data,
    input  logic     in_valid,
    output logic     in_ready,
    output payload_t out_data,
    output logic     out_valid,
    input  logic     out_ready
);

    logic     full;
    payload_t data_q;

    // Accepts a new entry while the old one leaves
    assign in_ready  = !full || out_ready;
    assign out_valid = full;
    assign out_data  = data_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            full <= 1'b0;
        end else if (in_valid && in_ready) begin
            full <= 1'b1;
        end else if (out_ready) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            data_q <= in_data;
        end
    end

endmodule

/* ctrl_seq.sv */
`include "ctrl_settings.svh"

module ctrl_seq (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [`CTRL_DATA_W-1:0]  op,
    input  logic                     op_valid,
    output logic                     op_ready,
    output logic [`CTRL_LEN_W-1:0]   fetched,
    input  logic [`CTRL_FLAGS_W-1:0] flags,
    output ctrl_pkg::alu_cmd_t       alu_data,
    output logic                     alu_valid,
    input  logic                     alu_ready,
    output ctrl_pkg::pc_cmd_t        pc_data,
    output logic                     pc_valid,
    input  logic                     pc_ready
);
    import ctrl_pkg::*;

    typedef enum logic {PH_FETCH, PH_FILL} phase_e;

    phase_e                 phase;
    logic                   run;
    logic                   pend_alu;                       // Pending instruction has an ALU part
    logic                   room;
    logic                   accept;
    logic                   load;
    alu_cmd_t               dec_alu;
    alu_cmd_t               fill_alu;
    logic                   dec_alu_en;
    pc_cmd_t                dec_pc;
    pc_cmd_t                fill_pc;
    logic [`CTRL_LEN_W-1:0] dec_fetched;
    logic [`CTRL_LEN_W-1:0] fill_len;
    logic                   dec_need_fill;
    size_e                  dec_fill_size;

    op_decode u_dec (
        .op        (op),
        .flags     (flags),
        .alu       (dec_alu),
        .alu_en    (dec_alu_en),
        .pc        (dec_pc),
        .fetched   (dec_fetched),
        .need_fill (dec_need_fill),
        .fill_size (dec_fill_size)
    );

    imm_fill u_fill (
        .clk      (clk),
        .rst      (rst),
        .load     (load),
        .alu_in   (dec_alu),
        .pc_in    (dec_pc),
        .size     (dec_fill_size),
        .op       (op),
        .alu_out  (fill_alu),
        .pc_out   (fill_pc),
        .fill_len (fill_len)
    );

    // First window of a two-window instruction writes no slot
    always_comb begin
        if (phase == PH_FILL) begin
            room = pc_ready && (!pend_alu || alu_ready);
        end else begin
            room = dec_need_fill || (pc_ready && (!dec_alu_en || alu_ready));
        end
    end

    assign op_ready = run && room;
    assign accept   = op_valid && op_ready;
    assign load     = accept && (phase == PH_FETCH) && dec_need_fill;

    always_comb begin
        if (phase == PH_FILL) begin
            alu_data  = fill_alu;
            pc_data   = fill_pc;
            alu_valid = accept && pend_alu;
            pc_valid  = accept;
            fetched   = accept ? fill_len : '0;
        end else begin
            alu_data  = dec_alu;
            pc_data   = dec_pc;
            alu_valid = accept && dec_alu_en && !dec_need_fill;
            pc_valid  = accept && !dec_need_fill;
            fetched   = accept ? dec_fetched : '0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            run      <= 1'b0;
            phase    <= PH_FETCH;
            pend_alu <= 1'b0;
        end else begin
            run <= 1'b1;                                    // Ready one cycle after release
            if (accept) begin
                if (phase == PH_FILL) begin
                    phase <= PH_FETCH;
                end else if (dec_need_fill) begin
                    phase    <= PH_FILL;
                    pend_alu <= dec_alu_en;
                end
            end
        end
    end

endmodule

/* ctrl_top.sv */
`include "ctrl_settings.svh"

module ctrl_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [`CTRL_DATA_W-1:0]  op,
    input  logic                     op_valid,
    output logic                     op_ready,
    output logic [`CTRL_LEN_W-1:0]   fetched,
    input  logic [`CTRL_FLAGS_W-1:0] flags,
    output ctrl_pkg::alu_cmd_t       alu_cmd,
    output logic                     alu_valid,
    input  logic                     alu_ready,
    output ctrl_pkg::pc_cmd_t        pc_cmd,
    output logic                     pc_valid,
    input  logic                     pc_ready
);
    import ctrl_pkg::*;

    alu_cmd_t alu_push_data;
    logic     alu_push_valid;
    logic     alu_push_ready;
    pc_cmd_t  pc_push_data;
    logic     pc_push_valid;
    logic     pc_push_ready;

    ctrl_seq u_seq (
        .clk       (clk),
        .rst       (rst),
        .op        (op),
        .op_valid  (op_valid),
        .op_ready  (op_ready),
        .fetched   (fetched),
        .flags     (flags),
        .alu_data  (alu_push_data),
        .alu_valid (alu_push_valid),
        .alu_ready (alu_push_ready),
        .pc_data   (pc_push_data),
        .pc_valid  (pc_push_valid),
        .pc_ready  (pc_push_ready)
    );

    cmd_slot #(.payload_t(alu_cmd_t)) u_alu_slot (
        .clk       (clk),
        .rst       (rst),
        .in_data   (alu_push_data),
        .in_valid  (alu_push_valid),
        .in_ready  (alu_push_ready),
        .out_data  (alu_cmd),
        .out_valid (alu_valid),
        .out_ready (alu_ready)
    );

    cmd_slot #(.payload_t(pc_cmd_t)) u_pc_slot (
        .clk       (clk),
        .rst       (rst),
        .in_data   (pc_push_data),
        .in_valid  (pc_push_valid),
        .in_ready  (pc_push_ready),
        .out_data  (pc_cmd),
        .out_valid (pc_valid),
        .out_ready (pc_ready)
    );

endmodule

/* tb_ctrl.sv */
`include "ctrl_settings.svh"

module tb_ctrl;
    import ctrl_pkg::*;

    localparam int PERIOD = 40;

    logic                     clk;
    logic                     rst;
    logic [`CTRL_DATA_W-1:0]  op;
    logic                     op_valid;
    logic                     op_ready;
    logic [`CTRL_LEN_W-1:0]   fetched;
    logic [`CTRL_FLAGS_W-1:0] flags;
    alu_cmd_t                 alu_cmd;
    logic                     alu_valid;
    logic                     alu_ready;
    pc_cmd_t                  pc_cmd;
    logic                     pc_valid;
    logic                     pc_ready;

    integer     seed;
    logic [7:0] prog[$];                        // Byte stream of the running test
    int         ptr;
    int         remaining;                      // Bytes still owed by the current instruction
    int         exp_fetch;
    int         n_instr;
    int         n_tests;
    int         checks;
    int         errors;
    int         rnd_kind;
    logic       active;
    logic       bp_mode;
    string      test_name;
    longint     deadline;
    alu_cmd_t   alu_exp[$];
    pc_cmd_t    pc_exp[$];
    alu_cmd_t   ref_alu;
    pc_cmd_t    ref_pc;
    logic       ref_has_alu;
    logic       ref_split;
    alu_cmd_t   alu_want;
    pc_cmd_t    pc_want;
    alu_cmd_t   alu_held;
    pc_cmd_t    pc_held;
    logic       alu_hold;
    logic       pc_hold;

    ctrl_top u_dut (
        .clk       (clk),
        .rst       (rst),
        .op        (op),
        .op_valid  (op_valid),
        .op_ready  (op_ready),
        .fetched   (fetched),
        .flags     (flags),
        .alu_cmd   (alu_cmd),
        .alu_valid (alu_valid),
        .alu_ready (alu_ready),
        .pc_cmd    (pc_cmd),
        .pc_valid  (pc_valid),
        .pc_ready  (pc_ready)
    );

    always #(PERIOD / 2) clk = ~clk;

    function automatic logic [7:0] byte_at(input int idx);
        return (idx < prog.size()) ? prog[idx] : 8'h00;     // Zero past the end
    endfunction

    function automatic logic cond_holds(input logic [3:0] cc, input logic [7:0] fl);
        logic lt;
        logic r;
        lt = fl[FLAG_S] != fl[FLAG_V];
        case (cc[2:0])
            3'd0: r = 1'b0;
            3'd1: r = lt;
            3'd2: r = fl[FLAG_Z] || lt;
            3'd3: r = fl[FLAG_Z] || fl[FLAG_C];
            3'd4: r = fl[FLAG_V];
            3'd5: r = fl[FLAG_S];
            3'd6: r = fl[FLAG_Z];
            default: r = fl[FLAG_C];
        endcase
        return cc[3] ? !r : r;                              // Upper half negates
    endfunction

    // Expected commands for the instruction whose bytes start at b[7:0]
    function automatic void expected_cmds(input logic [39:0] b, input logic [7:0] fl,
                                          output alu_cmd_t ea, output logic has_alu,
                                          output pc_cmd_t ep, output logic split);
        logic [7:0] op0;
        logic [2:0] r;
        int         d;
        op0     = b[7:0];
        r       = op0[2:0];
        ea      = '0;
        ep      = '0;
        has_alu = 1'b0;
        split   = 1'b0;
        ep.len  = 3'd1;
        if (op0 inside {[8'h10:8'h13]}) begin
            has_alu    = 1'b1;
            ea.flag_we = 1'b1;
            case (op0[1:0])
                2'd0: ea.alu_op = ALU_RCF;
                2'd1: ea.alu_op = ALU_SCF;
                2'd2: ea.alu_op = ALU_CCF;
                default: ea.alu_op = ALU_ZCF;
            endcase
        end else if (op0 inside {[8'h20:8'h27], [8'h30:8'h37], [8'h40:8'h47]}) begin
            has_alu   = 1'b1;
            ea.alu_op = ALU_MOVE;
            ea.smux   = 1'b1;
            ea.dst    = 8'he0 + {3'd0, r, 2'b00};           // Word and long registers
            if (op0[7:4] == 4'h2) begin
                ea.dst     = 8'he0 + {4'd0, r[2:1], 2'b00} + {7'd0, !r[0]};
                ea.regs_we = 3'b001;
                ea.imm     = {24'd0, b[15:8]};
                ep.len     = 3'd2;
            end else if (op0[7:4] == 4'h3) begin
                ea.regs_we = 3'b010;
                ea.imm     = {16'd0, b[23:8]};
                ep.len     = 3'd3;
                split      = 1'b1;
            end else begin
                ea.regs_we = 3'b100;
                ea.imm     = b[39:8];
                ep.len     = 3'd5;
                split      = 1'b1;
            end
        end else if (op0 == 8'h1a || op0 == 8'h1b) begin
            ep.jump   = JUMP_ABS;
            ep.target = op0[0] ? {8'd0, b[31:8]} : {16'd0, b[23:8]};
            ep.len    = op0[0] ? 3'd4 : 3'd3;
            split     = 1'b1;
        end else if (op0 inside {[8'h60:8'h7f]}) begin
            if (op0[4]) begin
                d      = int'($signed(b[23:8])) + 3;
                ep.len = 3'd3;
            end else begin
                d      = int'($signed(b[15:8])) + 2;
                ep.len = 3'd2;
            end
            if (cond_holds(op0[3:0], fl)) begin
                ep.jump   = JUMP_REL;
                ep.target = 32'(d);
            end
        end else if (op0 != 8'h00) begin
            ep.illegal = 1'b1;
        end
    endfunction

    function automatic logic [7:0] illegal_op(input logic [2:0] idx);
        case (idx)
            3'd0: return 8'h01;
            3'd1: return 8'h0f;
            3'd2: return 8'h14;
            3'd3: return 8'h19;
            3'd4: return 8'h1c;
            3'd5: return 8'h2f;
            3'd6: return 8'h50;
            default: return 8'hff;
        endcase
    endfunction

    // Kinds 0 NOP, 1 flag, 2-4 LD b/w/l, 5-6 JP, 7 JR, 8 JRL, else illegal
    task automatic add_instr(input int kind, input int sel);
        logic [7:0] low;
        logic [7:0] op0;
        int         extra;
        low = 8'(sel);
        case (kind)
            0: op0 = 8'h00;
            1: op0 = 8'h10 | (low & 8'h03);
            2: op0 = 8'h20 | (low & 8'h07);
            3: op0 = 8'h30 | (low & 8'h07);
            4: op0 = 8'h40 | (low & 8'h07);
            5: op0 = 8'h1a;
            6: op0 = 8'h1b;
            7: op0 = 8'h60 | (low & 8'h0f);
            8: op0 = 8'h70 | (low & 8'h0f);
            default: op0 = illegal_op(low[2:0]);
        endcase
        case (kind)
            2, 7: extra = 1;
            3, 5, 8: extra = 2;
            6: extra = 3;
            4: extra = 4;
            default: extra = 0;
        endcase
        prog.push_back(op0);
        repeat (extra) prog.push_back(8'($random(seed)));
    endtask

    task automatic run_test(input string name, input logic bp);
        int err_start;
        @(posedge clk);
        test_name = name;
        ptr       = 0;
        remaining = 0;
        n_instr   = 0;
        bp_mode   = bp;
        err_start = errors;
        deadline  = $time + longint'(prog.size() * 40 + 100) * PERIOD;
        active    = 1'b1;
        while (ptr < prog.size() || remaining != 0 || alu_exp.size() != 0 ||
               pc_exp.size() != 0) begin
            @(negedge clk);
        end
        repeat (4) @(posedge clk);                          // Catch stray commands
        active  = 1'b0;
        bp_mode = 1'b0;
        n_tests++;
        $display("%-10s done, %0d instructions, %0d errors", name, n_instr, errors - err_start);
    endtask

    always @(negedge clk) begin
        op        = {byte_at(ptr + 3), byte_at(ptr + 2), byte_at(ptr + 1), byte_at(ptr)};
        op_valid  = active && (ptr < prog.size());
        flags     = 8'($random(seed));
        alu_ready = bp_mode ? 1'($random(seed)) : 1'b1;
        pc_ready  = bp_mode ? 1'($random(seed)) : 1'b1;
    end

    // Window accepted
    always @(posedge clk) begin
        if (!rst && op_valid && op_ready) begin
            if (remaining == 0) begin
                expected_cmds({byte_at(ptr + 4), byte_at(ptr + 3), byte_at(ptr + 2),
                               byte_at(ptr + 1), byte_at(ptr)}, flags,
                              ref_alu, ref_has_alu, ref_pc, ref_split);
                if (ref_has_alu) begin
                    alu_exp.push_back(ref_alu);
                end
                pc_exp.push_back(ref_pc);
                remaining = int'(ref_pc.len);
                exp_fetch = ref_split ? 2 : remaining;      // Opcode and low byte first
                n_instr++;
            end else begin
                exp_fetch = remaining;
            end
            checks++;
            if (int'(fetched) != exp_fetch) begin
                $display("ERR %s fetched expected %0d actual %0d", test_name, exp_fetch, fetched);
                errors++;
            end
            ptr       += exp_fetch;
            remaining -= exp_fetch;
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            checks++;
            if (op_ready || alu_valid || pc_valid) begin
                $display("op_ready, alu_valid or pc_valid is high during reset");
                errors++;
            end
        end else begin
            if (alu_hold && (!alu_valid || alu_cmd !== alu_held)) begin
                $display("%s: alu_cmd changed or dropped while alu_ready was low", test_name);
                errors++;
            end
            if (pc_hold && (!pc_valid || pc_cmd !== pc_held)) begin
                $display("%s: pc_cmd changed or dropped while pc_ready was low", test_name);
                errors++;
            end
            alu_hold = alu_valid && !alu_ready;
            alu_held = alu_cmd;
            pc_hold  = pc_valid && !pc_ready;
            pc_held  = pc_cmd;
            if (alu_valid && alu_ready) begin
                if (alu_exp.size() == 0) begin
                    $display("%s: alu_cmd %h arrived with none expected", test_name, alu_cmd);
                    errors++;
                end else begin
                    alu_want = alu_exp.pop_front();
                    checks++;
                    if (alu_cmd !== alu_want) begin
                        $display("ERR %s alu_cmd expected %h actual %h",
                                 test_name, alu_want, alu_cmd);
                        errors++;
                    end
                end
            end
            if (pc_valid && pc_ready) begin
                if (pc_exp.size() == 0) begin
                    $display("%s: pc_cmd %h arrived with none expected", test_name, pc_cmd);
                    errors++;
                end else begin
                    pc_want = pc_exp.pop_front();
                    checks++;
                    if (pc_cmd !== pc_want) begin
                        $display("ERR %s pc_cmd expected %h actual %h", test_name, pc_want, pc_cmd);
                        errors++;
                    end
                end
            end
        end
    end

    initial begin
        while (deadline == 0 || $time <= deadline) begin
            @(posedge clk);
        end
        $display("Timeout in test %s, the DUT stopped taking or giving commands", test_name);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        op        = '0;
        op_valid  = 1'b0;
        flags     = '0;
        alu_ready = 1'b0;
        pc_ready  = 1'b0;
        seed      = `CTRL_TB_SEED;
        ptr       = 0;
        remaining = 0;
        n_instr   = 0;
        n_tests   = 0;
        checks    = 0;
        errors    = 0;
        rnd_kind  = 0;
        active    = 1'b0;
        bp_mode   = 1'b0;
        alu_hold  = 1'b0;
        pc_hold   = 1'b0;
        test_name = "reset";
        deadline  = 0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(posedge clk);
        @(posedge clk);
        checks++;
        if (!op_ready) begin
            $display("op_ready did not rise in the first cycle after reset release");
            errors++;
        end

        prog.delete();
        for (int i = 0; i < 3; i++) begin
            add_instr(0, 0);
            for (int f = 0; f < 4; f++) add_instr(1, f);
        end
        run_test("flag_nop", 1'b0);

        prog.delete();
        for (int r = 0; r < 8; r++) begin
            for (int k = 2; k <= 4; k++) add_instr(k, r);
        end
        run_test("ld_imm", 1'b0);

        prog.delete();
        for (int i = 0; i < 32; i++) begin
            add_instr(7, i);                                // Flags are random every cycle
            add_instr(8, i);
        end
        run_test("jr_jrl", 1'b0);

        prog.delete();
        for (int i = 0; i < 6; i++) begin
            add_instr(5, 0);
            add_instr(6, 0);
        end
        run_test("jp_abs", 1'b0);

        prog.delete();
        for (int i = 0; i < 8; i++) begin
            add_instr(9, i);
            add_instr(2, i);                                // Realignment after the skip
        end
        run_test("illegal", 1'b0);

        prog.delete();
        for (int i = 0; i < 80; i++) begin
            rnd_kind = $unsigned($random(seed)) % 10;
            add_instr(rnd_kind, $random(seed));
        end
        run_test("random_bp", 1'b1);

        $display("%0d tests, %0d checks, %0d errors", n_tests, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+.
ctrl_pkg.sv
cond_eval.sv
op_decode.sv
imm_fill.sv
cmd_slot.sv
ctrl_seq.sv
ctrl_top.sv
tb_ctrl.sv

/* Bender.yml */
package:
  name: ctrl_top

sources:
  - include_dirs:
      - .
    files:
      - ctrl_pkg.sv
      - cond_eval.sv
      - op_decode.sv
      - imm_fill.sv
      - cmd_slot.sv
      - ctrl_seq.sv
      - ctrl_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_ctrl.sv
